// ==== Makefile ====
# Verilator build and run of the serial port testbench

TOP := uart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --top-module $(TOP) -f list.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/uart_pkg.sv ====
// shared definitions for the memory-mapped serial port
//   vector typedefs for bytes, bus words and bit indices
//   state encodings of the transmitter and receiver FSMs
//   bit positions of the flags inside the data and control registers

package uart_pkg;

   // ------------------------------------------------------------
   // vector types
   // ------------------------------------------------------------
   typedef logic [7:0]  byte_t;
   typedef logic [31:0] word_t;
   typedef logic [2:0]  bit_idx_t;

   // ------------------------------------------------------------
   // FSM encodings
   // ------------------------------------------------------------
   typedef enum logic [1:0] {tx_st_idle, tx_st_start, tx_st_data, tx_st_stop} tx_state_e;
   typedef enum logic [1:0] {rx_st_idle, rx_st_start, rx_st_data, rx_st_stop} rx_state_e;

   // ------------------------------------------------------------
   // register layout
   // ------------------------------------------------------------
   // data register: available count in the upper half, valid flag below it
   localparam int rvalid_pos  = 15;
   localparam int ravail_lsb  = 16;
   // control register: sticky overrun flag and the write-space count
   localparam int overrun_pos = 10;
   localparam int wspace_lsb  = 16;

endpackage

// ==== design/uart_regs.sv ====
// bus front end of the serial port
//   register 0 (data): transmit on write, received byte with flags on read
//   register 1 (control): write space and sticky overrun flag
//   one-byte pending buffer for the receiver, registered read data

`timescale 1ns/1ps

module uart_regs (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            address,
   input  logic            writeenable,
   input  uart_pkg::word_t writedata,
   input  logic            readenable,
   input  logic            tx_busy,
   input  logic            rx_valid,
   input  uart_pkg::byte_t rx_data,
   output uart_pkg::word_t readdata,
   output logic            tx_start,
   output uart_pkg::byte_t tx_data
);

   uart_pkg::byte_t pend_data;
   uart_pkg::word_t rd_word;
   logic            pend_avail;
   logic            overrun;
   logic            wr_data;
   logic            wr_ctrl;
   logic            rd_data;

   // bus strobe decode, one cycle per access
   assign wr_data = writeenable && !address;
   assign wr_ctrl = writeenable && address;
   assign rd_data = readenable && !address;

   // ------------------------------------------------------------
   // transmit strobe
   // ------------------------------------------------------------
   // a write while a frame is still going out is lost
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         tx_start <= 1'b0;
      else
         tx_start <= wr_data && !tx_busy;
   end

   // byte for the transmitter, taken only together with the strobe
   always_ff @(posedge clk) begin
      if (wr_data && !tx_busy)
         tx_data <= writedata[7:0];
   end

   // ------------------------------------------------------------
   // pending receive byte and overrun flag
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend_avail <= 1'b0;
         overrun    <= 1'b0;
      end else begin
         // reading the data register consumes the pending byte
         if (rd_data)
            pend_avail <= 1'b0;
         // writing a one to the overrun bit clears the flag
         if (wr_ctrl && writedata[uart_pkg::overrun_pos])
            overrun <= 1'b0;
         // a new byte wins over both of the above
         if (rx_valid) begin
            pend_avail <= 1'b1;
            // an unread byte that is not being read right now gets lost
            if (pend_avail && !rd_data)
               overrun <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid)
         pend_data <= rx_data;
   end

   // ------------------------------------------------------------
   // read mux
   // ------------------------------------------------------------
   always_comb begin
      rd_word = '0;
      if (!address) begin
         rd_word[uart_pkg::ravail_lsb +: 16] = 16'(pend_avail);
         rd_word[uart_pkg::rvalid_pos]       = pend_avail;
         // the byte field is zero when nothing is pending
         rd_word[7:0] = pend_avail ? pend_data : 8'h00;
      end else begin
         rd_word[uart_pkg::wspace_lsb +: 16] = 16'(!tx_busy);
         rd_word[uart_pkg::overrun_pos]      = overrun;
      end
   end

   // read data shows up one edge after the strobe and is zero otherwise
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         readdata <= '0;
      else if (readenable)
         readdata <= rd_word;
      else
         readdata <= '0;
   end

endmodule

// ==== design/uart_rx.sv ====
// serial receiver
//   two-flop synchronizer on the incoming line
//   start-bit detection on a falling edge with a mid-bit re-check
//   mid-bit sampling of eight data bits, LSB first
//   stop-bit check, frames with a low stop bit are dropped

`timescale 1ns/1ps

module uart_rx #(
   parameter int bit_cycles = 8
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            serial_in,
   output logic            rx_valid,
   output uart_pkg::byte_t rx_data
);

   localparam int cnt_w = $clog2(bit_cycles);
   localparam int half  = bit_cycles / 2;

   uart_pkg::rx_state_e state;
   uart_pkg::bit_idx_t  idx;
   logic [cnt_w-1:0]    cnt;
   logic [1:0]          sync;
   logic                line_d;
   logic                line;
   logic                fall;
   logic                mid_start;
   logic                bit_end;

   // ------------------------------------------------------------
   // input synchronizer and edge detect
   // ------------------------------------------------------------
   // the flops reset high so that reset release is not seen as a start bit
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync   <= 2'b11;
         line_d <= 1'b1;
      end else begin
         sync   <= {sync[0], serial_in};
         line_d <= line;
      end
   end

   assign line = sync[1];
   assign fall = line_d & ~line;

   // half a bit after the falling edge is the middle of the start bit
   assign mid_start = (cnt == cnt_w'(half - 1));
   // from there on every full bit period lands in the middle of a bit
   assign bit_end   = (cnt == cnt_w'(bit_cycles - 1));

   // ------------------------------------------------------------
   // frame FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= uart_pkg::rx_st_idle;
         cnt      <= '0;
         idx      <= '0;
         rx_valid <= 1'b0;
      end else begin
         // rx_valid is a single-cycle pulse
         rx_valid <= 1'b0;
         case (state)
            uart_pkg::rx_st_idle: begin
               if (fall) begin
                  state <= uart_pkg::rx_st_start;
                  cnt   <= '0;
               end
            end
            uart_pkg::rx_st_start: begin
               if (mid_start) begin
                  cnt <= '0;
                  idx <= '0;
                  // a glitch that is gone by mid-bit is no start bit
                  if (line)
                     state <= uart_pkg::rx_st_idle;
                  else
                     state <= uart_pkg::rx_st_data;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            uart_pkg::rx_st_data: begin
               if (bit_end) begin
                  cnt <= '0;
                  if (idx == 3'd7)
                     state <= uart_pkg::rx_st_stop;
                  else
                     idx <= idx + 1'b1;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin
               // middle of the stop bit, a low line here is a framing error
               if (bit_end) begin
                  state    <= uart_pkg::rx_st_idle;
                  cnt      <= '0;
                  rx_valid <= line;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // data bits arrive LSB first and enter at the top of the shift register
   always_ff @(posedge clk) begin
      if (state == uart_pkg::rx_st_data && bit_end)
         rx_data <= {line, rx_data[7:1]};
   end

endmodule

// ==== design/uart_top.sv ====
// top level of the memory-mapped serial port
//   derives the bit period from the clock and the baud rate
//   connects the bus front end, the transmitter and the receiver

`timescale 1ns/1ps

module uart_top #(
   parameter int clk_hz = 250_000_000,
   parameter int baud   = 31_250_000
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            serial_in,
   output logic            serial_out,
   input  logic            address,
   input  logic            writeenable,
   input  uart_pkg::word_t writedata,
   input  logic            readenable,
   output uart_pkg::word_t readdata
);

   // clocks per serial bit, both serial blocks need at least 4
   localparam int bit_cycles = clk_hz / baud;

   logic            tx_start;
   logic            tx_busy;
   logic            rx_valid;
   uart_pkg::byte_t tx_data;
   uart_pkg::byte_t rx_data;

   uart_regs uart_regs_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .address     (address),
      .writeenable (writeenable),
      .writedata   (writedata),
      .readenable  (readenable),
      .tx_busy     (tx_busy),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data),
      .readdata    (readdata),
      .tx_start    (tx_start),
      .tx_data     (tx_data)
   );

   uart_tx #(.bit_cycles(bit_cycles)) uart_tx_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .tx_start   (tx_start),
      .tx_data    (tx_data),
      .serial_out (serial_out),
      .tx_busy    (tx_busy)
   );

   uart_rx #(.bit_cycles(bit_cycles)) uart_rx_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .serial_in (serial_in),
      .rx_valid  (rx_valid),
      .rx_data   (rx_data)
   );

endmodule

// ==== design/uart_tx.sv ====
// serial transmitter
//   one start bit, eight data bits LSB first, one stop bit
//   bit period of bit_cycles clocks, busy while a frame is on the line

`timescale 1ns/1ps

module uart_tx #(
   parameter int bit_cycles = 8
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           tx_start,
   input  uart_pkg::byte_t tx_data,
   output logic           serial_out,
   output logic           tx_busy
);

   localparam int cnt_w = $clog2(bit_cycles);

   uart_pkg::tx_state_e state;
   uart_pkg::bit_idx_t  idx;
   uart_pkg::byte_t     shift;
   logic [cnt_w-1:0]    cnt;
   logic                bit_end;

   // last clock of the current bit period
   assign bit_end = (cnt == cnt_w'(bit_cycles - 1));

   // the line is owned by the FSM from the start bit up to the end of the stop bit
   assign tx_busy = (state != uart_pkg::tx_st_idle);

   // ------------------------------------------------------------
   // frame FSM and line driver
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= uart_pkg::tx_st_idle;
         cnt        <= '0;
         idx        <= '0;
         serial_out <= 1'b1;
      end else begin
         case (state)
            uart_pkg::tx_st_idle: begin
               // a start request drops the line on the very next edge
               if (tx_start) begin
                  state      <= uart_pkg::tx_st_start;
                  cnt        <= '0;
                  serial_out <= 1'b0;
               end
            end
            uart_pkg::tx_st_start: begin
               if (bit_end) begin
                  state      <= uart_pkg::tx_st_data;
                  cnt        <= '0;
                  idx        <= '0;
                  serial_out <= shift[0];
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            uart_pkg::tx_st_data: begin
               if (bit_end) begin
                  cnt <= '0;
                  if (idx == 3'd7) begin
                     // all data bits are out, so the stop bit follows
                     state      <= uart_pkg::tx_st_stop;
                     serial_out <= 1'b1;
                  end else begin
                     idx        <= idx + 1'b1;
                     serial_out <= shift[1];
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin
               // stop bit, the line is already high
               if (bit_end) begin
                  state <= uart_pkg::tx_st_idle;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // shift register, bit 0 holds the bit on the line during the data phase
   always_ff @(posedge clk) begin
      if (state == uart_pkg::tx_st_idle && tx_start)
         shift <= tx_data;
      else if (state == uart_pkg::tx_st_data && bit_end)
         shift <= {1'b0, shift[7:1]};
   end

endmodule

// ==== list.f ====
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_top.sv
+incdir+sim
sim/uart_tb.sv

// ==== sim/uart_tb_tasks.svh ====
// testbench helpers for the serial port
//   expected register words built from the register layout
//   compare tasks for bus words, serial bytes and line levels
//   bus read and write, polling of the write space and the data register
//   serial frame driver and frame monitor

// ------------------------------------------------------------
// expected register words
// ------------------------------------------------------------
// count and valid flag are both 1 while a byte waits, the byte field is 0 otherwise
function automatic uart_pkg::word_t data_word(input logic avail, input uart_pkg::byte_t data);
   uart_pkg::word_t w;
   w = '0;
   w[uart_pkg::ravail_lsb] = avail;
   w[uart_pkg::rvalid_pos] = avail;
   if (avail)
      w[7:0] = data;
   return w;
endfunction

function automatic uart_pkg::word_t ctrl_word(input logic wspace, input logic ovr);
   uart_pkg::word_t w;
   w = '0;
   w[uart_pkg::wspace_lsb]  = wspace;
   w[uart_pkg::overrun_pos] = ovr;
   return w;
endfunction

// ------------------------------------------------------------
// compare tasks
// ------------------------------------------------------------
task automatic check_word(input uart_pkg::word_t got, exp, input string msg);
   if (got !== exp) begin
      $display("ERR %0d ns: %s read %h, expected %h", $time, msg, got, exp);
      error_count++;
   end
endtask

task automatic check_byte(input uart_pkg::byte_t got, exp, input string msg);
   if (got !== exp) begin
      $display("ERR %0d ns: %s is %h, expected %h", $time, msg, got, exp);
      error_count++;
   end
endtask

task automatic check_line(input logic got, exp, input string msg);
   if (got !== exp) begin
      $display("ERR %0d ns: %s is %b, expected %b", $time, msg, got, exp);
      error_count++;
   end
endtask

// ------------------------------------------------------------
// bus access, entered and left on a falling edge
// ------------------------------------------------------------
task automatic bus_write(input logic addr, input uart_pkg::word_t data);
   address     = addr;
   writedata   = data;
   writeenable = 1'b1;
   @(negedge clk);
   writeenable = 1'b0;
   writedata   = '0;
endtask

// readdata is loaded at the rising edge that samples the strobe
task automatic bus_read(input logic addr, output uart_pkg::word_t data);
   address    = addr;
   readenable = 1'b1;
   @(negedge clk);
   readenable = 1'b0;
   data       = readdata;
endtask

// poll the control register until the write space reads as wanted
task automatic wait_write_space(input logic want);
   uart_pkg::word_t rd;
   int              polls;
   polls = 0;
   bus_read(1'b1, rd);
   while (rd[uart_pkg::wspace_lsb] !== want && polls < 2 * frame_cycles) begin
      bus_read(1'b1, rd);
      polls++;
   end
   if (rd[uart_pkg::wspace_lsb] !== want) begin
      $display("write space never reached %0d while polling", want);
      error_count++;
   end
endtask

// read register 0 and consume the model's pending byte
task automatic read_data_reg(input string msg);
   uart_pkg::word_t rd;
   int              polls;
   polls = 0;
   bus_read(1'b0, rd);
   // when a byte is expected, keep reading until its valid flag shows up
   while (model_avail && !rd[uart_pkg::rvalid_pos] && polls < frame_cycles) begin
      bus_read(1'b0, rd);
      polls++;
   end
   check_word(rd, data_word(model_avail, model_byte), msg);
   model_avail = 1'b0;
endtask

// ------------------------------------------------------------
// serial line driver and monitor
// ------------------------------------------------------------
// a bad frame has a low stop bit and leaves the model alone
task automatic send_frame(input uart_pkg::byte_t data, input logic bad_stop);
   int i;
   serial_in = 1'b0;
   repeat (bit_cycles) @(negedge clk);
   for (i = 0; i < 8; i++) begin
      serial_in = data[i];
      repeat (bit_cycles) @(negedge clk);
   end
   serial_in = !bad_stop;
   repeat (bit_cycles) @(negedge clk);
   serial_in = 1'b1;
   // two idle bits, the byte is in the data register well before they end
   repeat (2 * bit_cycles) @(negedge clk);
   if (!bad_stop) begin
      if (model_avail)
         model_overrun = 1'b1;
      model_avail = 1'b1;
      model_byte  = data;
   end
endtask

// decodes one frame from serial_out, sampling every bit at its middle
task automatic capture_frame(output uart_pkg::byte_t data, output logic ok);
   int waited;
   int i;
   data   = '0;
   ok     = 1'b0;
   waited = 0;
   while (serial_out && waited < 4 * frame_cycles) begin
      @(negedge clk);
      waited++;
   end
   if (serial_out) begin
      $display("no start bit appeared on serial_out");
      error_count++;
   end else begin
      repeat (bit_cycles / 2) @(negedge clk);
      check_line(serial_out, 1'b0, "middle of start bit");
      for (i = 0; i < 8; i++) begin
         repeat (bit_cycles) @(negedge clk);
         data[i] = serial_out;
      end
      repeat (bit_cycles) @(negedge clk);
      check_line(serial_out, 1'b1, "middle of stop bit");
      ok = 1'b1;
   end
endtask

// ==== sim/uart_tb.sv ====
// testbench for the memory-mapped serial port
//   clock, reset and a watchdog scaled to the length of the tests
//   receive-side model with the pending byte, available and overrun flags
//   six tests on random data, one report line per test

`timescale 1ns/1ps

module uart_tb;

   localparam int clk_hz       = 250_000_000;
   localparam int baud         = 31_250_000;
   localparam int bit_cycles   = clk_hz / baud;
   localparam int frame_cycles = 10 * bit_cycles;
   localparam int reset_cycles = 10;
   localparam int num_tests    = 6;
   // 20 frame times per test on top of the reset, at 4 ns per clock
   localparam int watchdog_ns  = (num_tests * 20 * frame_cycles + reset_cycles) * 4;

   logic            clk;
   logic            rst_n;
   logic            serial_in;
   logic            serial_out;
   logic            address;
   logic            writeenable;
   logic            readenable;
   uart_pkg::word_t writedata;
   uart_pkg::word_t readdata;

   int              error_count;
   int              errors_at_start;
   int              tests_passed;
   int              tests_failed;

   // what the receive side of the DUT should hold
   logic            model_avail;
   logic            model_overrun;
   uart_pkg::byte_t model_byte;

   uart_top #(
      .clk_hz (clk_hz),
      .baud   (baud)
   ) uart_top_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .serial_in   (serial_in),
      .serial_out  (serial_out),
      .address     (address),
      .writeenable (writeenable),
      .writedata   (writedata),
      .readenable  (readenable),
      .readdata    (readdata)
   );

   always #2 clk = ~clk;

   `include "uart_tb_tasks.svh"

   task automatic report_test(input int num, input string name);
      if (error_count == errors_at_start) begin
         tests_passed++;
         $display("test %0d, %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("test %0d, %s: %0d errors", num, name, error_count - errors_at_start);
      end
      errors_at_start = error_count;
   endtask

   initial begin
      #(watchdog_ns);
      $display("timeout, the tests did not finish within %0d ns", watchdog_ns);
      $display("sim failed");
      $finish;
   end

   initial begin
      uart_pkg::word_t rd;
      uart_pkg::word_t wr;
      uart_pkg::byte_t sent;
      uart_pkg::byte_t seen;
      logic            ok;
      int              n;
      clk             = 1'b0;
      rst_n           = 1'b0;
      serial_in       = 1'b1;
      address         = 1'b0;
      writeenable     = 1'b0;
      writedata       = '0;
      readenable      = 1'b0;
      error_count     = 0;
      errors_at_start = 0;
      tests_passed    = 0;
      tests_failed    = 0;
      model_avail     = 1'b0;
      model_overrun   = 1'b0;
      model_byte      = '0;
      void'($urandom(32'hb6cc420f));
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // idle line, empty data register, free transmitter
      check_line(serial_out, 1'b1, "serial_out after reset");
      check_word(readdata, '0, "readdata after reset");
      read_data_reg("data register after reset");
      bus_read(1'b1, rd);
      check_word(rd, ctrl_word(1'b1, 1'b0), "control register after reset");
      report_test(1, "reset state");

      for (n = 0; n < 20; n++) begin
         sent = 8'($urandom);
         wait_write_space(1'b1);
         fork
            begin
               bus_write(1'b0, {24'h0, sent});
               // the transmitter leaves idle on the edge after the write
               repeat (2) @(negedge clk);
               bus_read(1'b1, rd);
               check_word(rd, ctrl_word(1'b0, model_overrun), "control during a frame");
            end
            capture_frame(seen, ok);
         join
         if (ok)
            check_byte(seen, sent, "transmitted byte");
      end
      report_test(2, "transmit");

      for (n = 0; n < 20; n++) begin
         send_frame(8'($urandom), 1'b0);
         read_data_reg("received byte");
         read_data_reg("second read of the data register");
      end
      report_test(3, "receive");

      // the second byte overwrites the first, which was never read
      send_frame(8'($urandom), 1'b0);
      send_frame(8'($urandom), 1'b0);
      read_data_reg("data register after overrun");
      bus_read(1'b1, rd);
      check_word(rd, ctrl_word(1'b1, model_overrun), "control with overrun set");
      wr = '0;
      wr[uart_pkg::overrun_pos] = 1'b1;
      bus_write(1'b1, wr);
      model_overrun = 1'b0;
      bus_read(1'b1, rd);
      check_word(rd, ctrl_word(1'b1, model_overrun), "control after overrun clear");
      report_test(4, "overrun");

      sent = 8'($urandom);
      wait_write_space(1'b1);
      fork
         begin
            bus_write(1'b0, {24'h0, sent});
            wait_write_space(1'b0);
            bus_write(1'b0, {24'h0, ~sent});
         end
         capture_frame(seen, ok);
      join
      if (ok)
         check_byte(seen, sent, "byte before the dropped write");
      // a frame from the dropped write would pull the line low in here
      for (n = 0; n < frame_cycles + bit_cycles && serial_out; n++)
         @(negedge clk);
      check_line(serial_out, 1'b1, "serial_out after the dropped write");
      report_test(5, "write while busy");

      send_frame(8'($urandom), 1'b1);
      read_data_reg("data register after a framing error");
      send_frame(8'($urandom), 1'b0);
      read_data_reg("good frame after a framing error");
      report_test(6, "framing error");

      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule
